// File: hw/bluePkg.sv
package bluePkg;

   // one machine word on the accumulator, the bus and in core
   parameter int dataWidth = 16;
   // 4K words of core unless the top level says otherwise
   parameter int addrWidthDefault = 12;
   // minor steps in one major cycle
   parameter int numSteps = 8;

   // opcode field in instruction bits 15..12
   parameter logic [3:0] opHlt = 4'h0;
   parameter logic [3:0] opLda = 4'h1;
   parameter logic [3:0] opSta = 4'h2;
   parameter logic [3:0] opAdd = 4'h3;
   parameter logic [3:0] opSub = 4'h4;
   parameter logic [3:0] opAnd = 4'h5;
   parameter logic [3:0] opIor = 4'h6;
   parameter logic [3:0] opXor = 4'h7;
   parameter logic [3:0] opJmp = 4'h8;
   parameter logic [3:0] opLdi = 4'h9;
   parameter logic [3:0] opSkp = 4'ha;
   parameter logic [3:0] opOpr = 4'hb;

   // operate group, selected by instruction bits 3..0
   parameter logic [3:0] oprNop = 4'h0;
   parameter logic [3:0] oprNot = 4'h1;
   parameter logic [3:0] oprInc = 4'h2;
   parameter logic [3:0] oprDec = 4'h3;
   parameter logic [3:0] oprRal = 4'h4;
   parameter logic [3:0] oprRar = 4'h5;

   // what the ALU puts out when it drives the bus
   typedef enum logic [2:0] {
      aluSum,
      aluDiff,
      aluAnd,
      aluOr,
      aluXor,
      aluNot,
      aluRal,
      aluRar
   } aluSel;

endpackage

// File: hw/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer (
   input  logic clk,
   input  logic mclear,
   input  logic start,
   input  logic stop,
   input  logic exam,
   input  logic deposit,
   input  logic halt,
   output logic [bluePkg::numSteps-1:0] cp,
   output logic [bluePkg::numSteps-1:0] cpw,
   output logic running,
   output logic panelExam,
   output logic panelDeposit
);
   import bluePkg::*;

   localparam logic [3:0] lastHalf = 4'(2 * numSteps - 1);

   // panel switches, bit 0 start, 1 stop, 2 exam, 3 deposit
   logic [3:0] panelMeta;
   logic [3:0] panelSync;
   logic [3:0] panelLast;
   logic [3:0] panelRise;
   // two clocks per minor step, low bit picks the write half
   logic [3:0] halfCnt;
   logic active;
   logic cycleEnd;
   logic startReq;
   logic stopReq;

   assign panelRise = panelSync & ~panelLast;
   assign active = running | panelExam | panelDeposit;
   assign cycleEnd = active && (halfCnt == lastHalf);

   always_ff @(posedge clk or posedge mclear) begin
      if (mclear) begin
         panelMeta <= '0;
         panelSync <= '0;
         panelLast <= '0;
      end else begin
         panelMeta <= {deposit, exam, stop, start};
         panelSync <= panelMeta;
         panelLast <= panelSync;
      end
   end

   // wraps back to zero by itself at the end of each major cycle
   always_ff @(posedge clk or posedge mclear) begin
      if (mclear) begin
         halfCnt <= '0;
      end else if (active) begin
         halfCnt <= halfCnt + 4'd1;
      end
   end

   always_ff @(posedge clk or posedge mclear) begin
      if (mclear) begin
         running <= 1'b0;
         startReq <= 1'b0;
         stopReq <= 1'b0;
         panelExam <= 1'b0;
         panelDeposit <= 1'b0;
      end else begin
         // start is only heard while halted, taken when the machine is idle
         if (!active && startReq) begin
            startReq <= 1'b0;
         end else if (panelRise[0] && !running) begin
            startReq <= 1'b1;
         end
         // stop switch or HLT, honoured at the cycle boundary
         if (cycleEnd) begin
            stopReq <= 1'b0;
         end else if (halt || (panelRise[1] && running)) begin
            stopReq <= 1'b1;
         end
         if (!active) begin
            if (startReq) begin
               running <= 1'b1;
            end else begin
               // exam wins if both switches come up together
               panelExam <= panelRise[2];
               panelDeposit <= panelRise[3] & ~panelRise[2];
            end
         end else if (cycleEnd) begin
            running <= running & ~(stopReq | panelRise[1]);
            panelExam <= 1'b0;
            panelDeposit <= 1'b0;
         end
      end
   end

   // one read pulse per step, write pulse in its second clock only
   always_comb begin
      cp = '0;
      cpw = '0;
      if (active) begin
         cp[halfCnt[3:1]] = 1'b1;
         cpw[halfCnt[3:1]] = halfCnt[0];
      end
   end

endmodule

// File: hw/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
   input  logic [bluePkg::dataWidth-1:0] ir,
   output logic isHlt,
   output logic isLda,
   output logic isSta,
   output logic isAdd,
   output logic isSub,
   output logic isAnd,
   output logic isIor,
   output logic isXor,
   output logic isJmp,
   output logic isLdi,
   output logic isSkp,
   output logic isNot,
   output logic isInc,
   output logic isDec,
   output logic isRal,
   output logic isRar
);
   import bluePkg::*;

   logic [3:0] opField;
   logic [3:0] subField;
   logic isOpr;

   // opcode sits in the top nibble
   assign opField = ir[dataWidth-1 -: 4];
   assign subField = ir[3:0];
   assign isOpr = (opField == opOpr);

   assign isHlt = (opField == opHlt);
   assign isLda = (opField == opLda);
   assign isSta = (opField == opSta);
   assign isAdd = (opField == opAdd);
   assign isSub = (opField == opSub);
   assign isAnd = (opField == opAnd);
   assign isIor = (opField == opIor);
   assign isXor = (opField == opXor);
   assign isJmp = (opField == opJmp);
   assign isLdi = (opField == opLdi);
   assign isSkp = (opField == opSkp);

   // operate group, unused sub-codes fall through as NOP
   assign isNot = isOpr && (subField == oprNot);
   assign isInc = isOpr && (subField == oprInc);
   assign isDec = isOpr && (subField == oprDec);
   assign isRal = isOpr && (subField == oprRal);
   assign isRar = isOpr && (subField == oprRar);

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
   input  logic [bluePkg::dataWidth-1:0] y,
   input  logic [bluePkg::dataWidth-1:0] z,
   input  bluePkg::aluSel sel,
   input  logic carryIn,
   output logic [bluePkg::dataWidth-1:0] result,
   output logic carry,
   output logic zero,
   output logic overflow
);
   import bluePkg::*;

   logic [dataWidth:0] sumWide;
   logic [dataWidth:0] diffWide;
   logic signSame;

   assign sumWide = {1'b0, z} + {1'b0, y};
   // top bit of the difference is the borrow
   assign diffWide = {1'b0, z} - {1'b0, y};
   assign signSame = (z[dataWidth-1] == y[dataWidth-1]);

   always_comb begin
      result = sumWide[dataWidth-1:0];
      carry = carryIn;
      overflow = 1'b0;
      unique case (sel)
         aluSum: begin
            result = sumWide[dataWidth-1:0];
            carry = sumWide[dataWidth];
            overflow = signSame && (sumWide[dataWidth-1] != z[dataWidth-1]);
         end
         aluDiff: begin
            result = diffWide[dataWidth-1:0];
            carry = diffWide[dataWidth];
            overflow = !signSame && (diffWide[dataWidth-1] != z[dataWidth-1]);
         end
         aluAnd: result = z & y;
         aluOr: result = z | y;
         aluXor: result = z ^ y;
         aluNot: result = ~z;
         // rotates go through the carry, 17 bits around
         aluRal: {carry, result} = {z, carryIn};
         aluRar: {result, carry} = {carryIn, z};
      endcase
   end

   assign zero = (result == '0);

endmodule

// File: hw/blueCpu.sv
`timescale 1ns/1ps

module blueCpu #(
   parameter int addrWidth = bluePkg::addrWidthDefault
) (
   input  logic clk,
   input  logic mclear,
   input  logic [bluePkg::numSteps-1:0] cp,
   input  logic [bluePkg::numSteps-1:0] cpw,
   input  logic panelExam,
   input  logic panelDeposit,
   input  logic loadPc,
   input  logic [bluePkg::dataWidth-1:0] swReg,
   input  logic [bluePkg::dataWidth-1:0] memRdData,
   output logic [addrWidth-1:0] memAddr,
   output logic [bluePkg::dataWidth-1:0] memWrData,
   output logic memWrite,
   output logic halt,
   output logic [bluePkg::dataWidth-1:0] acc,
   output logic [addrWidth-1:0] pc,
   output logic [bluePkg::dataWidth-1:0] ir
);
   import bluePkg::*;

   typedef enum logic [3:0] {
      srcZero, srcPc, srcMem, srcIrAddr, srcAcc, srcAlu, srcOne, srcOnes, srcSw
   } busSrc;

   busSrc busSel;
   aluSel aluFn;
   logic [dataWidth-1:0] bus;
   logic [dataWidth-1:0] yReg;
   logic [dataWidth-1:0] zReg;
   logic [dataWidth-1:0] aluOut;
   logic [addrWidth-1:0] mar;
   logic [2:0] flagWord;
   logic aluCarry, aluZero, aluOver;
   logic cFlag, zFlag, oFlag;
   logic wrMar, wrZ, wrY, wrIr, wrAcc, wrPc;
   logic isHlt, isLda, isSta, isAdd, isSub, isAnd, isIor, isXor;
   logic isJmp, isLdi, isSkp, isNot, isInc, isDec, isRal, isRar;
   logic strobe;
   logic panel;
   logic arithOp;
   logic refOp;
   logic accOp;
   logic skipTaken;
   logic flagWrite;

   instrDecode i_instrDecode (
      .ir(ir), .isHlt(isHlt), .isLda(isLda), .isSta(isSta), .isAdd(isAdd),
      .isSub(isSub), .isAnd(isAnd), .isIor(isIor), .isXor(isXor), .isJmp(isJmp),
      .isLdi(isLdi), .isSkp(isSkp), .isNot(isNot), .isInc(isInc), .isDec(isDec),
      .isRal(isRal), .isRar(isRar)
   );

   aluUnit i_aluUnit (
      .y(yReg), .z(zReg), .sel(aluFn), .carryIn(cFlag),
      .result(aluOut), .carry(aluCarry), .zero(aluZero), .overflow(aluOver)
   );

   // cpw is only ever up inside its own cp step
   assign strobe = |cpw;
   assign panel = panelExam | panelDeposit;
   assign arithOp = isAdd | isSub | isAnd | isIor | isXor;
   assign refOp = arithOp | isLda | isSta;
   assign accOp = isNot | isInc | isDec | isRal | isRar;
   // mask picks from C, Z, O and bit 3 inverts them first
   assign flagWord = {cFlag, zFlag, oFlag};
   assign skipTaken = |((ir[3] ? ~flagWord : flagWord) & ir[2:0]);
   assign halt = cp[6] & isHlt & ~panel;
   assign memAddr = mar;
   assign memWrData = bus;

   // per-step transfers, steps 0..3 fetch and 4..7 execute
   always_comb begin
      busSel = srcZero;
      aluFn = aluSum;
      wrMar = 1'b0;
      wrZ = 1'b0;
      wrY = 1'b0;
      wrIr = 1'b0;
      wrAcc = 1'b0;
      wrPc = 1'b0;
      memWrite = 1'b0;
      if (cp[0]) begin
         busSel = srcPc;
         wrMar = strobe;
         wrZ = strobe;
      end else if (cp[1]) begin
         // panel cycles leave IR alone so the lamps keep the last instruction
         busSel = srcMem;
         wrIr = strobe & ~panel;
      end else if (cp[2]) begin
         busSel = srcOne;
         wrY = strobe;
      end else if (cp[3]) begin
         busSel = srcAlu;
         wrPc = strobe;
      end else if (cp[4]) begin
         if (panelExam) begin
            busSel = srcMem;
            wrAcc = strobe;
         end else if (panelDeposit) begin
            busSel = srcSw;
            memWrite = strobe;
         end else if (refOp) begin
            busSel = srcIrAddr;
            wrMar = strobe;
         end else if (isJmp) begin
            busSel = srcIrAddr;
            wrPc = strobe;
         end else if (accOp) begin
            busSel = srcAcc;
            wrZ = strobe;
         end else if (isSkp || isLdi) begin
            busSel = srcPc;
            wrZ = strobe;
            wrMar = strobe & isLdi;
         end
      end else if (cp[5] && !panel) begin
         if (refOp) begin
            busSel = srcAcc;
            wrZ = strobe;
         end else if (isNot || isRal || isRar) begin
            busSel = srcAlu;
            aluFn = isNot ? aluNot : (isRal ? aluRal : aluRar);
            wrAcc = strobe;
         end else if (isLdi || (isSkp && skipTaken)) begin
            // Y still holds one from the fetch
            busSel = srcAlu;
            wrPc = strobe;
         end
      end else if (cp[6] && !panel) begin
         if (arithOp) begin
            busSel = srcMem;
            wrY = strobe;
         end else if (isDec) begin
            busSel = srcOnes;
            wrY = strobe;
         end else if (isLdi) begin
            busSel = srcMem;
            wrAcc = strobe;
         end
      end else if (cp[7] && !panel) begin
         if (isSta) begin
            busSel = srcAcc;
            memWrite = strobe;
         end else if (isLda) begin
            busSel = srcMem;
            wrAcc = strobe;
         end else if (arithOp || isInc || isDec) begin
            busSel = srcAlu;
            wrAcc = strobe;
            if (isSub) aluFn = aluDiff;
            else if (isAnd) aluFn = aluAnd;
            else if (isIor) aluFn = aluOr;
            else if (isXor) aluFn = aluXor;
         end
      end
   end

   always_comb begin
      case (busSel)
         srcPc: bus = dataWidth'(pc);
         srcMem: bus = memRdData;
         srcIrAddr: bus = dataWidth'(ir[addrWidth-1:0]);
         srcAcc: bus = acc;
         srcAlu: bus = aluOut;
         srcOne: bus = dataWidth'(1);
         srcOnes: bus = '1;
         srcSw: bus = swReg;
         default: bus = '0;
      endcase
   end

   // flags follow every ALU result written to the accumulator
   assign flagWrite = wrAcc && (busSel == srcAlu);

   always_ff @(posedge clk or posedge mclear) begin
      if (mclear) begin
         ir <= '0;
         acc <= '0;
         pc <= '0;
         cFlag <= 1'b0;
         zFlag <= 1'b0;
         oFlag <= 1'b0;
      end else begin
         if (wrIr) ir <= bus;
         if (wrAcc) acc <= bus;
         // switch register load only while the sequencer is idle
         if (wrPc) begin
            pc <= bus[addrWidth-1:0];
         end else if (loadPc && (cp == '0)) begin
            pc <= swReg[addrWidth-1:0];
         end
         if (flagWrite) begin
            zFlag <= aluZero;
            if (aluFn inside {aluSum, aluDiff, aluRal, aluRar}) cFlag <= aluCarry;
            if (aluFn inside {aluSum, aluDiff}) oFlag <= aluOver;
         end
      end
   end

   // MAR and the ALU operand registers
   always_ff @(posedge clk) begin
      if (wrMar) mar <= bus[addrWidth-1:0];
      if (wrY) yReg <= bus;
      if (wrZ) zReg <= bus;
   end

endmodule

// File: hw/coreMemory.sv
`timescale 1ns/1ps

module coreMemory #(
   parameter int addrWidth = bluePkg::addrWidthDefault
) (
   input  logic clk,
   input  logic [addrWidth-1:0] addr,
   input  logic [bluePkg::dataWidth-1:0] wrData,
   input  logic write,
   output logic [bluePkg::dataWidth-1:0] rdData
);
   import bluePkg::*;

   logic [dataWidth-1:0] words [2**addrWidth];

   // write lands at the end of the cpw clock
   always_ff @(posedge clk) begin
      if (write) begin
         words[addr] <= wrData;
      end
   end

   // reads are combinational, MAR holds the address steady
   assign rdData = words[addr];

endmodule

// File: hw/blueSystem.sv
`timescale 1ns/1ps

module blueSystem #(
   parameter int addrWidth = bluePkg::addrWidthDefault
) (
   input  logic clk,
   input  logic mclear,
   input  logic start,
   input  logic stop,
   input  logic exam,
   input  logic deposit,
   input  logic loadPc,
   input  logic [bluePkg::dataWidth-1:0] swReg,
   output logic [bluePkg::dataWidth-1:0] acc,
   output logic [addrWidth-1:0] pc,
   output logic [bluePkg::dataWidth-1:0] ir,
   output logic running
);
   import bluePkg::*;

   logic [numSteps-1:0] cp;
   logic [numSteps-1:0] cpw;
   logic panelExam;
   logic panelDeposit;
   logic halt;
   logic [addrWidth-1:0] memAddr;
   logic [dataWidth-1:0] memWrData;
   logic [dataWidth-1:0] memRdData;
   logic memWrite;

   cycleSequencer i_cycleSequencer (
      .clk(clk), .mclear(mclear), .start(start), .stop(stop), .exam(exam),
      .deposit(deposit), .halt(halt), .cp(cp), .cpw(cpw), .running(running),
      .panelExam(panelExam), .panelDeposit(panelDeposit)
   );

   blueCpu #(.addrWidth(addrWidth)) i_blueCpu (
      .clk(clk), .mclear(mclear), .cp(cp), .cpw(cpw), .panelExam(panelExam),
      .panelDeposit(panelDeposit), .loadPc(loadPc), .swReg(swReg),
      .memRdData(memRdData), .memAddr(memAddr), .memWrData(memWrData),
      .memWrite(memWrite), .halt(halt), .acc(acc), .pc(pc), .ir(ir)
   );

   coreMemory #(.addrWidth(addrWidth)) i_coreMemory (
      .clk(clk), .addr(memAddr), .wrData(memWrData), .write(memWrite),
      .rdData(memRdData)
   );

endmodule

// File: sim/blueSystem_checker.sv
`timescale 1ns/1ps

module blueSystem_checker (
   input logic clk,
   input logic mclear,
   input logic [bluePkg::numSteps-1:0] cp,
   input logic [bluePkg::numSteps-1:0] cpw,
   input logic running
);

   // only one minor step may be live at a time
   stepOneHot: assert property (@(posedge clk) disable iff (mclear) $onehot0(cp))
      else $error("more than one cp bit high: %b", cp);

   // write pulse belongs to the second clock of its own step
   writeInStep: assert property (@(posedge clk) disable iff (mclear) (cpw & ~cp) == '0)
      else $error("cpw %b outside its cp step %b", cpw, cp);

   // run flag moves at the major-cycle boundary, with the sequencer idle on one side
   runAtBoundary: assert property (@(posedge clk) disable iff (mclear)
      (running != $past(running)) |-> ((cp == '0) || ($past(cp) == '0)))
      else $error("running changed in the middle of a major cycle");

endmodule

// File: sim/blueMonitor.sv
`timescale 1ns/1ps

module blueMonitor #(
   parameter int addrWidth = bluePkg::addrWidthDefault
) (
   input logic mclear,
   input logic deposit,
   input logic [bluePkg::dataWidth-1:0] swReg,
   input logic [bluePkg::dataWidth-1:0] acc,
   input logic [addrWidth-1:0] pc,
   input logic [bluePkg::dataWidth-1:0] ir,
   input logic running
);
   import bluePkg::*;

   // shadow of core, plus the programmer-visible state
   logic [dataWidth-1:0] shadow [2**addrWidth];
   logic [dataWidth-1:0] mAcc;
   logic [addrWidth-1:0] mPc;
   logic mC;
   logic mZ;
   logic mO;
   int errors;

   // flags and accumulator come out of mclear cleared
   initial begin
      errors = 0;
      mAcc = '0;
      mPc = '0;
      mC = 1'b0;
      mZ = 1'b0;
      mO = 1'b0;
   end

   // a halted deposit lands at the current pc
   always @(posedge deposit) begin
      if (!running && !mclear) begin
         shadow[pc] = swReg;
      end
   end

   task automatic compareWord(input string name, input logic [dataWidth-1:0] actual,
                              input logic [dataWidth-1:0] expected);
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic noteFailure(input string what);
      errors++;
      $display("at %0t: %s", $time, what);
   endtask

   task automatic checkPc(input logic [addrWidth-1:0] expected);
      compareWord("pc", dataWidth'(pc), dataWidth'(expected));
   endtask

   // examine puts the word into acc and steps pc
   task automatic checkExam(input logic [addrWidth-1:0] addr);
      logic [addrWidth-1:0] nextAddr;
      nextAddr = addr + 1'b1;
      compareWord("acc", acc, shadow[addr]);
      compareWord("pc", dataWidth'(pc), dataWidth'(nextAddr));
      mAcc = shadow[addr];
   endtask

   // ir lamp keeps the HLT word that ended the run
   task automatic checkHalted();
      compareWord("acc", acc, mAcc);
      compareWord("pc", dataWidth'(pc), dataWidth'(mPc));
      compareWord("ir", ir, shadow[mPc - 1'b1]);
      if (running) begin
         noteFailure("running is still high after the program halted");
      end
   endtask

   // two's complement add, carry out and signed overflow
   task automatic addModel(input logic [dataWidth-1:0] y);
      logic [dataWidth:0] wide;
      wide = {1'b0, mAcc} + {1'b0, y};
      mO = (mAcc[dataWidth-1] == y[dataWidth-1]) && (wide[dataWidth-1] != mAcc[dataWidth-1]);
      mC = wide[dataWidth];
      mAcc = wide[dataWidth-1:0];
      mZ = (mAcc == '0);
   endtask

   // instruction-set model, runs from an address up to HLT
   task automatic runModel(input logic [addrWidth-1:0] from);
      logic [dataWidth-1:0] w;
      logic [dataWidth-1:0] m;
      logic [dataWidth:0] wide;
      logic [2:0] f;
      logic done;
      int n;
      mPc = from;
      done = 1'b0;
      n = 0;
      while (!done && n < 4000) begin
         w = shadow[mPc];
         mPc = mPc + 1'b1;
         m = shadow[w[addrWidth-1:0]];
         n++;
         case (w[dataWidth-1 -: 4])
            opHlt: done = 1'b1;
            opLda: mAcc = m;
            opSta: shadow[w[addrWidth-1:0]] = mAcc;
            opAdd: addModel(m);
            opSub: begin
               // carry holds the borrow
               wide = {1'b0, mAcc} - {1'b0, m};
               mO = (mAcc[dataWidth-1] != m[dataWidth-1])
                    && (wide[dataWidth-1] != mAcc[dataWidth-1]);
               mC = wide[dataWidth];
               mAcc = wide[dataWidth-1:0];
               mZ = (mAcc == '0);
            end
            opAnd: begin
               mAcc = mAcc & m;
               mZ = (mAcc == '0);
            end
            opIor: begin
               mAcc = mAcc | m;
               mZ = (mAcc == '0);
            end
            opXor: begin
               mAcc = mAcc ^ m;
               mZ = (mAcc == '0);
            end
            opJmp: mPc = w[addrWidth-1:0];
            opLdi: begin
               mAcc = shadow[mPc];
               mPc = mPc + 1'b1;
            end
            opSkp: begin
               f = {mC, mZ, mO};
               if (w[3]) f = ~f;
               if ((f & w[2:0]) != 3'b000) mPc = mPc + 1'b1;
            end
            opOpr: begin
               case (w[3:0])
                  oprNot: mAcc = ~mAcc;
                  oprInc: addModel(dataWidth'(1));
                  oprDec: addModel('1);
                  // rotate through carry, 17 bits around
                  oprRal: {mC, mAcc} = {mAcc, mC};
                  oprRar: {mAcc, mC} = {mC, mAcc};
                  default: ;
               endcase
               if (w[3:0] inside {oprNot, oprRal, oprRar}) mZ = (mAcc == '0);
            end
            default: ;
         endcase
      end
      if (!done) noteFailure("reference model never reached HLT");
   endtask

endmodule

// File: sim/tb_blueSystem.sv
`timescale 1ns/1ps

module tb_blueSystem;
   import bluePkg::*;

   localparam int addrWidth = addrWidthDefault;
   // rough sum over the five tests, a panel transfer costs about two major cycles
   localparam int majorCycles = 80 + 280 + 240 + 20 + 380;
   localparam int cycleLimit = majorCycles * 16 + 4000;

   logic clk;
   logic mclear;
   logic start;
   logic stop;
   logic exam;
   logic deposit;
   logic loadPc;
   logic [dataWidth-1:0] swReg;
   logic [dataWidth-1:0] acc;
   logic [dataWidth-1:0] ir;
   logic [addrWidth-1:0] pc;
   logic running;
   logic [31:0] rngState;
   int cycles;
   int testsRun;
   int testsFailed;
   int errBefore;

   blueSystem #(.addrWidth(addrWidth)) i_blueSystem (
      .clk(clk), .mclear(mclear), .start(start), .stop(stop), .exam(exam),
      .deposit(deposit), .loadPc(loadPc), .swReg(swReg), .acc(acc), .pc(pc),
      .ir(ir), .running(running)
   );

   blueMonitor #(.addrWidth(addrWidth)) i_blueMonitor (
      .mclear(mclear), .deposit(deposit), .swReg(swReg), .acc(acc), .pc(pc),
      .ir(ir), .running(running)
   );

   bind cycleSequencer blueSystem_checker i_seqChecker (
      .clk(clk), .mclear(mclear), .cp(cp), .cpw(cpw), .running(running)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // watchdog on the total run length
   initial begin
      cycles = 0;
      while (cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: no result after %0d clock cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] nextRand();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   function automatic logic [dataWidth-1:0] instr(input logic [3:0] op,
                                                  input logic [11:0] field);
      return {op, field};
   endfunction

   // one of the eleven accumulator operations on the data block
   function automatic logic [dataWidth-1:0] randomOp(input logic [11:0] dataBase);
      logic [31:0] r;
      logic [11:0] a;
      r = nextRand();
      a = dataBase + {9'd0, r[18:16]};
      case (r[7:0] % 8'd11)
         8'd0: return instr(opLda, a);
         8'd1: return instr(opAdd, a);
         8'd2: return instr(opSub, a);
         8'd3: return instr(opAnd, a);
         8'd4: return instr(opIor, a);
         8'd5: return instr(opXor, a);
         8'd6: return instr(opOpr, {8'd0, oprNot});
         8'd7: return instr(opOpr, {8'd0, oprInc});
         8'd8: return instr(opOpr, {8'd0, oprDec});
         8'd9: return instr(opOpr, {8'd0, oprRal});
         default: return instr(opOpr, {8'd0, oprRar});
      endcase
   endfunction

   task automatic setPc(input logic [addrWidth-1:0] addr);
      @(posedge clk);
      swReg <= dataWidth'(addr);
      loadPc <= 1'b1;
      repeat (2) @(posedge clk);
      loadPc <= 1'b0;
      @(posedge clk);
      i_blueMonitor.checkPc(addr);
   endtask

   // switch up for two clocks, then sync stages plus one 16-clock panel cycle
   task automatic depositWord(input logic [dataWidth-1:0] data);
      @(posedge clk);
      swReg <= data;
      @(posedge clk);
      deposit <= 1'b1;
      repeat (2) @(posedge clk);
      deposit <= 1'b0;
      repeat (22) @(posedge clk);
   endtask

   task automatic examineWord(input logic [addrWidth-1:0] addr);
      @(posedge clk);
      exam <= 1'b1;
      repeat (2) @(posedge clk);
      exam <= 1'b0;
      repeat (22) @(posedge clk);
      i_blueMonitor.checkExam(addr);
   endtask

   task automatic loadProgram(input logic [addrWidth-1:0] addr,
                              input logic [dataWidth-1:0] words[$]);
      setPc(addr);
      foreach (words[i]) depositWord(words[i]);
   endtask

   task automatic pressStart();
      @(posedge clk);
      start <= 1'b1;
      repeat (2) @(posedge clk);
      start <= 1'b0;
      while (!running) @(posedge clk);
   endtask

   task automatic waitHalt();
      while (running) @(posedge clk);
      @(posedge clk);
   endtask

   task automatic runFrom(input logic [addrWidth-1:0] addr);
      i_blueMonitor.runModel(addr);
      setPc(addr);
      pressStart();
      waitHalt();
      i_blueMonitor.checkHalted();
   endtask

   task automatic reportTest(input int num, input string name);
      int errs;
      errs = i_blueMonitor.errors - errBefore;
      errBefore = i_blueMonitor.errors;
      testsRun++;
      if (errs > 0) testsFailed++;
      $display("test %0d %s: %s, %0d errors", num, name, (errs > 0) ? "failed" : "ok", errs);
   endtask

   initial begin
      logic [31:0] r;
      logic [11:0] base;
      logic [11:0] data;
      logic [dataWidth-1:0] prog[$];
      mclear = 1'b1;
      start = 1'b0;
      stop = 1'b0;
      exam = 1'b0;
      deposit = 1'b0;
      loadPc = 1'b0;
      swReg = '0;
      rngState = 32'd85878;
      testsRun = 0;
      testsFailed = 0;
      errBefore = 0;
      repeat (8) @(posedge clk);
      mclear <= 1'b0;
      repeat (2) @(posedge clk);

      // deposit a block, pc steps once per panel cycle, then read it back
      r = nextRand();
      base = 12'h400 + {4'd0, r[7:0]};
      setPc(base);
      for (int i = 0; i < 12; i++) begin
         r = nextRand();
         depositWord(r[15:0]);
         i_blueMonitor.checkPc(base + 12'(i + 1));
      end
      setPc(base);
      for (int i = 0; i < 12; i++) examineWord(base + 12'(i));
      reportTest(1, "deposit and examine");

      // random arithmetic and logic programs
      for (int t = 0; t < 4; t++) begin
         base = 12'h100 + 12'(t * 32);
         data = 12'h800 + 12'(t * 16);
         setPc(data);
         for (int i = 0; i < 8; i++) depositWord(16'(nextRand() >> 8));
         prog = {};
         prog.push_back(instr(opLda, data));
         for (int i = 0; i < 8; i++) prog.push_back(randomOp(data));
         prog.push_back(instr(opSta, data + 12'd8));
         prog.push_back(instr(opHlt, 12'd0));
         loadProgram(base, prog);
         runFrom(base);
         setPc(data + 12'd8);
         examineWord(data + 12'd8);
      end
      reportTest(2, "arithmetic program");

      // flag skip picks which store runs, then a forward jump
      for (int t = 0; t < 6; t++) begin
         base = 12'h300 + 12'(t * 16);
         data = 12'h900 + 12'(t * 8);
         setPc(data);
         depositWord(16'(nextRand() >> 16));
         depositWord(16'(nextRand() >> 16));
         depositWord(16'h0000);
         depositWord(16'h0000);
         r = nextRand();
         prog = {};
         prog.push_back(instr(opLda, data));
         case (r[9:8])
            2'd0: prog.push_back(instr(opAdd, data + 12'd1));
            2'd1: prog.push_back(instr(opSub, data + 12'd1));
            2'd2: prog.push_back(instr(opAnd, data + 12'd1));
            default: prog.push_back(instr(opXor, data + 12'd1));
         endcase
         prog.push_back(instr(opSkp, {8'd0, r[3:0]}));
         prog.push_back(instr(opSta, data + 12'd2));
         prog.push_back(instr(opJmp, base + 12'd6));
         prog.push_back(instr(opHlt, 12'd0));
         prog.push_back(instr(opSta, data + 12'd3));
         prog.push_back(instr(opHlt, 12'd0));
         loadProgram(base, prog);
         runFrom(base);
         setPc(data + 12'd2);
         examineWord(data + 12'd2);
         examineWord(data + 12'd3);
      end
      reportTest(3, "skip and jump");

      // immediate load, then halt leaves pc after the HLT
      // random low bits on the HLT show up on the ir lamp
      r = nextRand();
      prog = {};
      prog.push_back(instr(opLdi, 12'd0));
      prog.push_back(r[15:0]);
      prog.push_back(instr(opSta, 12'ha00));
      prog.push_back(instr(opHlt, r[27:16]));
      loadProgram(12'h500, prog);
      runFrom(12'h500);
      setPc(12'ha00);
      examineWord(12'ha00);
      reportTest(4, "LDI and halt");

      // counting loop, stopped part way and resumed
      r = nextRand();
      setPc(12'hb00);
      depositWord(16'h0000);
      depositWord(16'd20 + {11'd0, r[4:0]});
      prog = {};
      prog.push_back(instr(opLda, 12'hb00));
      prog.push_back(instr(opOpr, {8'd0, oprInc}));
      prog.push_back(instr(opSta, 12'hb00));
      prog.push_back(instr(opSub, 12'hb01));
      prog.push_back(instr(opSkp, 12'h002));
      prog.push_back(instr(opJmp, 12'h600));
      prog.push_back(instr(opHlt, 12'd0));
      loadProgram(12'h600, prog);
      i_blueMonitor.runModel(12'h600);
      setPc(12'h600);
      pressStart();
      repeat (16 * (4 + int'(r[13:8] % 6'd40))) @(posedge clk);
      stop <= 1'b1;
      repeat (2) @(posedge clk);
      stop <= 1'b0;
      waitHalt();
      if (pc < 12'h600 || pc > 12'h606) begin
         i_blueMonitor.noteFailure("stop left pc outside the loop");
      end
      pressStart();
      waitHalt();
      i_blueMonitor.checkHalted();
      setPc(12'hb00);
      examineWord(12'hb00);
      reportTest(5, "stop and resume");

      $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
               i_blueMonitor.errors);
      if (testsFailed == 0 && i_blueMonitor.errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: src.f
hw/bluePkg.sv
hw/cycleSequencer.sv
hw/instrDecode.sv
hw/aluUnit.sv
hw/blueCpu.sv
hw/coreMemory.sv
hw/blueSystem.sv
sim/blueSystem_checker.sv
sim/blueMonitor.sv
sim/tb_blueSystem.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_blueSystem -f src.f -o simv \
   && ./obj_dir/simv 2>&1 | tee sim.log \
   || { echo "build or simulation aborted"; exit 1; }

grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
